//--- common/rv_decode_pkg.sv
`default_nettype none

package rv_decode_pkg;

  //////////////////////////////////////////////////
  // Widths fixed by the ISA
  //////////////////////////////////////////////////

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  // funct3 of loads and stores, carried to the memory stage
  typedef logic [2:0]  mem_size_t;

  // Width of the pc field in id_ex_t
  // The top level PC_W is expected to match this value
  parameter int unsigned ID_EX_PC_W = 16;

  // ALU operation handed to execute
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_e;

  //////////////////////////////////////////////////
  // Control word and pipeline snapshots
  //////////////////////////////////////////////////

  typedef struct packed {
    alu_op_e   alu_op;
    logic      alusrc;
    logic      memread;
    logic      memwrite;
    logic      regwrite;
    mem_size_t mem_size;
    logic      branch;
    logic      jal;
    logic      jalr;
    logic      lui;
    logic      auipc;
  } ctrl_t;

  typedef struct packed {
    ctrl_t                   ctrl;
    reg_addr_t               rs1;
    reg_addr_t               rs2;
    reg_addr_t               rd;
    word_t                   rs1_val;
    word_t                   rs2_val;
    word_t                   imm;
    logic [ID_EX_PC_W-1:0]   pc;
  } id_ex_t;

  // EX/MEM view seen by decode
  typedef struct packed {
    logic      regwrite;
    logic      memread;
    reg_addr_t rd;
    word_t     alu_res;
  } ex_mem_t;

  // MEM/WB view, also the register file write port
  typedef struct packed {
    logic      regwrite;
    reg_addr_t rd;
    word_t     wb_res;
  } mem_wb_t;

  //////////////////////////////////////////////////
  // Opcodes
  //////////////////////////////////////////////////

  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_OP_IMM = 7'b0010011;
  localparam logic [6:0] OP_OP     = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // Full ECALL word, no operand bits set
  localparam word_t ECALL_INS = 32'h0000_0073;

endpackage

`default_nettype wire

//--- decode/rv_control.sv
`timescale 1ns/1ps
`default_nettype none

module rv_control (
  input  rv_decode_pkg::word_t ins,
  output rv_decode_pkg::ctrl_t ctrl
);
  import rv_decode_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  // funct7 bit 5 picks SUB and SRA
  logic       alt;

  assign opcode = ins[6:0];
  assign funct3 = ins[14:12];
  assign alt    = ins[30];

  // ALU operation from funct3 plus the alternate bit
  function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt_sel);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt_sel ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt_sel ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  //////////////////////////////////////////////////
  // Main decoder
  //////////////////////////////////////////////////

  always_comb
  begin
    // Empty or unknown slot leaves everything off
    ctrl = '0;
    case (opcode)
      OP_LUI:
      begin
        ctrl.regwrite = 1'b1;
        ctrl.alusrc   = 1'b1;
        ctrl.lui      = 1'b1;
      end
      OP_AUIPC:
      begin
        ctrl.regwrite = 1'b1;
        ctrl.alusrc   = 1'b1;
        ctrl.auipc    = 1'b1;
      end
      OP_JAL:
      begin
        // Link value pc + 4 is formed in execute
        ctrl.regwrite = 1'b1;
        ctrl.jal      = 1'b1;
      end
      OP_JALR:
      begin
        ctrl.regwrite = 1'b1;
        ctrl.alusrc   = 1'b1;
        ctrl.jalr     = 1'b1;
      end
      OP_BRANCH:
        // Resolved here in decode, ALU stays idle
        ctrl.branch = 1'b1;
      OP_LOAD:
      begin
        ctrl.regwrite = 1'b1;
        ctrl.memread  = 1'b1;
        ctrl.alusrc   = 1'b1;
        ctrl.mem_size = funct3;
      end
      OP_STORE:
      begin
        ctrl.memwrite = 1'b1;
        ctrl.alusrc   = 1'b1;
        ctrl.mem_size = funct3;
      end
      OP_OP_IMM:
      begin
        // Only SRAI uses bit 30, ADDI keeps it as immediate
        ctrl.regwrite = 1'b1;
        ctrl.alusrc   = 1'b1;
        ctrl.alu_op   = alu_from_f3(funct3, alt && (funct3 == 3'b101));
      end
      OP_OP:
      begin
        ctrl.regwrite = 1'b1;
        ctrl.alu_op   = alu_from_f3(funct3, alt);
      end
      default:
        // SYSTEM and the rest decode as no-op
        ctrl = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- decode/rv_imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module rv_imm_gen (
  input  rv_decode_pkg::word_t ins,
  output rv_decode_pkg::word_t imm
);
  import rv_decode_pkg::*;

  logic [6:0] opcode;
  // Sign bit shared by every format
  logic       sgn;

  assign opcode = ins[6:0];
  assign sgn    = ins[31];

  //////////////////////////////////////////////////
  // Format select and assembly
  //////////////////////////////////////////////////

  always_comb
  begin
    case (opcode)
      // I format
      OP_LOAD, OP_OP_IMM, OP_JALR:
        imm = {{20{sgn}}, ins[31:20]};
      // S format, split offset
      OP_STORE:
        imm = {{20{sgn}}, ins[31:25], ins[11:7]};
      // B format, offset in halfwords
      OP_BRANCH:
        imm = {{19{sgn}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      // U format
      OP_LUI, OP_AUIPC:
        imm = {ins[31:12], 12'h000};
      // J format
      OP_JAL:
        imm = {{11{sgn}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      // R type and anything else carry no immediate
      default:
        imm = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- decode/rv_hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module rv_hazard_unit (
  input  rv_decode_pkg::word_t     ins,
  input  rv_decode_pkg::ctrl_t     ctrl,
  input  rv_decode_pkg::ctrl_t     id_ex_ctrl,
  input  rv_decode_pkg::reg_addr_t id_ex_rd,
  input  rv_decode_pkg::ex_mem_t   ex_mem,
  output logic                     hz
);
  import rv_decode_pkg::*;

  reg_addr_t rs1;
  reg_addr_t rs2;
  logic      rs2_used;
  logic      cmp_rs1;
  logic      cmp_rs2;
  logic      load_use;
  logic      ex_dep;
  logic      mem_dep;

  // x0 never counts as a match
  function automatic logic addr_hit(input reg_addr_t src, input reg_addr_t dst);
    return (src != 5'd0) && (src == dst);
  endfunction

  assign rs1 = ins[19:15];
  assign rs2 = ins[24:20];

  // rs2 read by R type, store and branch
  assign rs2_used = (ins[6:0] == OP_OP) || ctrl.memwrite || ctrl.branch;

  // Sources compared in decode
  assign cmp_rs1 = ctrl.branch || ctrl.jalr;
  assign cmp_rs2 = ctrl.branch;

  // Load in ID/EX feeding this instruction
  assign load_use = id_ex_ctrl.memread &&
                    (addr_hit(rs1, id_ex_rd) || (rs2_used && addr_hit(rs2, id_ex_rd)));

  // Branch operand still in execute
  assign ex_dep = id_ex_ctrl.regwrite &&
                  ((cmp_rs1 && addr_hit(rs1, id_ex_rd)) || (cmp_rs2 && addr_hit(rs2, id_ex_rd)));

  // Branch operand still loading in MEM
  assign mem_dep = ex_mem.memread &&
                   ((cmp_rs1 && addr_hit(rs1, ex_mem.rd)) || (cmp_rs2 && addr_hit(rs2, ex_mem.rd)));

  assign hz = load_use || ex_dep || mem_dep;

endmodule

`default_nettype wire

//--- decode/rv_branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module rv_branch_unit #(
  parameter int unsigned PC_W = rv_decode_pkg::ID_EX_PC_W
) (
  input  rv_decode_pkg::word_t   ins,
  input  rv_decode_pkg::ctrl_t   ctrl,
  input  logic [PC_W-1:0]        pc,
  input  rv_decode_pkg::word_t   imm,
  input  rv_decode_pkg::word_t   rs1_val,
  input  rv_decode_pkg::word_t   rs2_val,
  input  rv_decode_pkg::ex_mem_t ex_mem,
  input  rv_decode_pkg::mem_wb_t mem_wb,
  input  logic                   hz,
  output logic                   branch_taken,
  output logic [PC_W-1:0]        branch_target
);
  import rv_decode_pkg::*;

  typedef logic [PC_W-1:0] pc_t;

  word_t op1;
  word_t op2;
  word_t base;
  word_t sum;
  pc_t   target;
  logic  cond;

  //////////////////////////////////////////////////
  // Operand forwarding
  //////////////////////////////////////////////////

  // EX/MEM first, then MEM/WB, then register file
  // A load in EX/MEM has no data yet, hazard unit stalls it
  function automatic word_t fwd(input reg_addr_t src, input word_t rf_val,
                                input ex_mem_t em, input mem_wb_t mw);
    word_t val;
    if (src != 5'd0 && em.regwrite && !em.memread && em.rd == src)
      val = em.alu_res;
    else if (src != 5'd0 && mw.regwrite && mw.rd == src)
      val = mw.wb_res;
    else
      val = rf_val;
    return val;
  endfunction

  assign op1 = fwd(ins[19:15], rs1_val, ex_mem, mem_wb);
  assign op2 = fwd(ins[24:20], rs2_val, ex_mem, mem_wb);

  //////////////////////////////////////////////////
  // Compare and target
  //////////////////////////////////////////////////

  always_comb
  begin
    case (ins[14:12])
      3'b000:  cond = (op1 == op2);
      3'b001:  cond = (op1 != op2);
      3'b100:  cond = ($signed(op1) < $signed(op2));
      3'b101:  cond = ($signed(op1) >= $signed(op2));
      3'b110:  cond = (op1 < op2);
      3'b111:  cond = (op1 >= op2);
      // Reserved funct3 never branches
      default: cond = 1'b0;
    endcase
  end

  // JALR adds to rs1, everything else to pc
  assign base = ctrl.jalr ? op1 : word_t'(pc);
  assign sum  = base + imm;

  // Bit 0 dropped for JALR, truncated to pc width
  assign target        = ctrl.jalr ? pc_t'({sum[31:1], 1'b0}) : pc_t'(sum);
  assign branch_target = target;

  // Never redirect on stale operands
  assign branch_taken = !hz && ((ctrl.branch && cond) || ctrl.jal || ctrl.jalr);

endmodule

`default_nettype wire

//--- decode/rv_id_ex_reg.sv
`timescale 1ns/1ps
`default_nettype none

module rv_id_ex_reg #(
  parameter int unsigned PC_W = rv_decode_pkg::ID_EX_PC_W
) (
  input  logic                  bus,
  input  logic                  rst,
  input  logic                  mem_hold,
  input  logic                  hz,
  input  logic                  branch_taken,
  input  rv_decode_pkg::id_ex_t d,
  output rv_decode_pkg::id_ex_t q
);
  import rv_decode_pkg::*;

  // Set after a taken branch or jump is captured
  logic            squash;
  logic            take_bubble;
  logic [PC_W-1:0] held_pc;
  id_ex_t          bubble;

  assign held_pc = d.pc;

  // Bubble keeps pc so execute still sees where it sits
  always_comb
  begin
    bubble             = '0;
    bubble.ctrl.alusrc = 1'b1;
    bubble.pc          = held_pc;
  end

  assign take_bubble = squash || hz;

  //////////////////////////////////////////////////
  // Pipeline register
  //////////////////////////////////////////////////

  always_ff @(posedge bus)
  begin
    if (rst)
    begin
      q      <= '0;
      squash <= 1'b0;
    end
    else if (!mem_hold)
    begin
      if (take_bubble)
        q <= bubble;
      else
        q <= d;
      // Wrong-path slot never arms another squash
      squash <= !squash && branch_taken;
    end
  end

endmodule

`default_nettype wire

//--- verilog/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
  input  logic                     bus,
  input  logic                     rst,
  input  rv_decode_pkg::reg_addr_t rs1,
  input  rv_decode_pkg::reg_addr_t rs2,
  input  logic                     we,
  input  rv_decode_pkg::reg_addr_t rd,
  input  rv_decode_pkg::word_t     wdata,
  output rv_decode_pkg::word_t     rs1_val,
  output rv_decode_pkg::word_t     rs2_val
);
  import rv_decode_pkg::*;

  // x1 to x31, x0 has no storage
  word_t regs [1:31];

  //////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////

  always_ff @(posedge bus)
  begin
    if (rst)
    begin
      for (int i = 1; i < 32; i++)
        regs[i] <= '0;
    end
    else if (we && rd != 5'd0)
      regs[rd] <= wdata;
  end

  // Reads are plain muxes, a write shows up next cycle
  assign rs1_val = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_val = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- verilog/rv_decode_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode_top #(
  // Should equal rv_decode_pkg::ID_EX_PC_W
  parameter int unsigned PC_W = rv_decode_pkg::ID_EX_PC_W
) (
  input  logic                   bus,
  input  logic                   rst,
  input  rv_decode_pkg::word_t   ins,
  input  logic [PC_W-1:0]        pc,
  input  logic                   mem_hold,
  input  rv_decode_pkg::ex_mem_t ex_mem,
  input  rv_decode_pkg::mem_wb_t mem_wb,
  output rv_decode_pkg::id_ex_t  id_ex,
  output logic                   hz,
  output logic                   branch_taken,
  output logic [PC_W-1:0]        branch_target,
  output logic                   ecall
);
  import rv_decode_pkg::*;

  ctrl_t  ctrl;
  word_t  imm;
  word_t  rs1_val;
  word_t  rs2_val;
  id_ex_t id_ex_d;

  //////////////////////////////////////////////////
  // Register file, written from write-back
  //////////////////////////////////////////////////

  rv_regfile rv_regfile_inst (
    .bus     (bus),
    .rst     (rst),
    .rs1     (ins[19:15]),
    .rs2     (ins[24:20]),
    .we      (mem_wb.regwrite),
    .rd      (mem_wb.rd),
    .wdata   (mem_wb.wb_res),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val)
  );

  //////////////////////////////////////////////////
  // Decode units
  //////////////////////////////////////////////////

  rv_control rv_control_inst (
    .ins  (ins),
    .ctrl (ctrl)
  );

  rv_imm_gen rv_imm_gen_inst (
    .ins (ins),
    .imm (imm)
  );

  // Fed back from the ID/EX register output
  rv_hazard_unit rv_hazard_unit_inst (
    .ins        (ins),
    .ctrl       (ctrl),
    .id_ex_ctrl (id_ex.ctrl),
    .id_ex_rd   (id_ex.rd),
    .ex_mem     (ex_mem),
    .hz         (hz)
  );

  rv_branch_unit #(.PC_W(PC_W)) rv_branch_unit_inst (
    .ins           (ins),
    .ctrl          (ctrl),
    .pc            (pc),
    .imm           (imm),
    .rs1_val       (rs1_val),
    .rs2_val       (rs2_val),
    .ex_mem        (ex_mem),
    .mem_wb        (mem_wb),
    .hz            (hz),
    .branch_taken  (branch_taken),
    .branch_target (branch_target)
  );

  // Decoded slot headed for execute
  assign id_ex_d.ctrl    = ctrl;
  assign id_ex_d.rs1     = ins[19:15];
  assign id_ex_d.rs2     = ins[24:20];
  assign id_ex_d.rd      = ins[11:7];
  assign id_ex_d.rs1_val = rs1_val;
  assign id_ex_d.rs2_val = rs2_val;
  assign id_ex_d.imm     = imm;
  assign id_ex_d.pc      = pc;

  rv_id_ex_reg #(.PC_W(PC_W)) rv_id_ex_reg_inst (
    .bus          (bus),
    .rst          (rst),
    .mem_hold     (mem_hold),
    .hz           (hz),
    .branch_taken (branch_taken),
    .d            (id_ex_d),
    .q            (id_ex)
  );

  // Exact encoding only
  assign ecall = (ins == ECALL_INS);

endmodule

`default_nettype wire

//--- sim/rv_decode_props.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode_props (
  input logic                  bus,
  input logic                  rst,
  input logic                  mem_hold,
  input logic                  hz,
  input rv_decode_pkg::id_ex_t id_ex
);
  import rv_decode_pkg::*;

  //////////////////////////////////////////////////
  // Reset and stall rules
  //////////////////////////////////////////////////

  // Empty slot right after reset
  reset_clears_ctrl: assert property (@(posedge bus) rst |=> id_ex.ctrl == '0)
    else $error("id_ex control not cleared by reset");

  // Stalled slot enters execute with no side effects
  stall_inserts_bubble: assert property (@(posedge bus) disable iff (rst)
    (hz && !mem_hold) |=>
      ({id_ex.ctrl.memread, id_ex.ctrl.memwrite, id_ex.ctrl.regwrite,
        id_ex.ctrl.branch, id_ex.ctrl.jal, id_ex.ctrl.jalr} == '0) && (id_ex.rd == '0))
    else $error("hazard stall did not insert a bubble into id_ex");

  // Back-pressure freezes the register
  hold_keeps_id_ex: assert property (@(posedge bus) disable iff (rst) mem_hold |=> $stable(id_ex))
    else $error("id_ex changed during mem_hold");

endmodule

bind rv_decode_top rv_decode_props rv_decode_props_inst (
  .bus      (bus),
  .rst      (rst),
  .mem_hold (mem_hold),
  .hz       (hz),
  .id_ex    (id_ex)
);

`default_nettype wire

//--- sim/rv_decode_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode_tb;
  import rv_decode_pkg::*;

  localparam int unsigned PC_W = 16;
  // Rough cycle count of reset plus all tests
  localparam int TEST_CYCLES = 70;
  localparam word_t NOP = 32'h0000_0000;

  typedef logic [PC_W-1:0] pc_t;

  logic    bus;
  logic    rst;
  word_t   ins;
  pc_t     pc;
  logic    mem_hold;
  ex_mem_t ex_mem;
  mem_wb_t mem_wb;
  id_ex_t  id_ex;
  logic    hz;
  logic    branch_taken;
  pc_t     branch_target;
  logic    ecall;

  // Copy of what the register file should hold
  word_t       rf_model [0:31];
  logic [31:0] seed = 32'hc6749853;

  rv_decode_top #(.PC_W(PC_W)) rv_decode_top_inst (
    .bus (bus), .rst (rst), .ins (ins), .pc (pc), .mem_hold (mem_hold),
    .ex_mem (ex_mem), .mem_wb (mem_wb), .id_ex (id_ex), .hz (hz),
    .branch_taken (branch_taken), .branch_target (branch_target), .ecall (ecall)
  );

  initial
  begin
    bus = 1'b0;
    forever #20 bus = ~bus;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // Flags in order alusrc memread memwrite regwrite, kind branch jal jalr lui auipc
  function automatic ctrl_t mk_ctrl(input alu_op_e op, input logic [3:0] amwr,
                                    input logic [2:0] size, input logic [4:0] kind);
    ctrl_t c;
    c = '0;
    c.alu_op = op;
    {c.alusrc, c.memread, c.memwrite, c.regwrite} = amwr;
    c.mem_size = size;
    {c.branch, c.jal, c.jalr, c.lui, c.auipc} = kind;
    return c;
  endfunction

  // Instruction encoders, immediates given as full words
  function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                  input reg_addr_t rs1, input logic [2:0] f3,
                                  input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, OP_OP};
  endfunction

  function automatic word_t enc_i(input word_t imm, input reg_addr_t rs1,
                                  input logic [2:0] f3, input reg_addr_t rd,
                                  input logic [6:0] op);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_b(input word_t imm, input logic [2:0] f3);
    // Branch sources fixed at x8 and x9
    return {imm[12], imm[10:5], 5'd9, 5'd8, f3, imm[4:1], imm[11], OP_BRANCH};
  endfunction

  // ISA compare per funct3
  function automatic logic branch_cond(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      3'b111:  return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  task automatic check(input string name, input logic [159:0] exp, input logic [159:0] act);
    if (exp !== act)
    begin
      $display("FAILED %s expected %0h actual %0h", name, exp, act);
      $display("STATUS: FAIL");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  // New fetch slot on the edge, sampled mid-cycle
  task automatic present(input word_t i, input pc_t p);
    @(posedge bus);
    ins <= i;
    pc  <= p;
    @(negedge bus);
  endtask

  task automatic expect_id_ex(input string name, input ctrl_t c, input reg_addr_t rd,
                              input word_t imm, input pc_t p);
    check({name, " ctrl"}, c, id_ex.ctrl);
    check({name, " rd"}, rd, id_ex.rd);
    check({name, " imm"}, imm, id_ex.imm);
    check({name, " pc"}, p, id_ex.pc);
  endtask

  task automatic expect_bubble(input string name, input pc_t p);
    expect_id_ex(name, mk_ctrl(ALU_ADD, 4'b1000, 3'd0, 5'd0), 5'd0, '0, p);
    check({name, " operands"}, 64'd0, {id_ex.rs1_val, id_ex.rs2_val});
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic reset_and_decode();
    check("reset id_ex", '0, id_ex);
    // Fill x1..x10 through write-back
    for (int r = 1; r < 11; r++)
    begin
      seed = xorshift(seed);
      @(posedge bus);
      mem_wb <= '{1'b1, reg_addr_t'(r), seed};
      rf_model[r] = seed;
    end
    @(posedge bus);
    mem_wb <= '0;
    present(enc_i(-5, 5'd1, 3'b000, 5'd11, OP_OP_IMM), 16'h0100);
    present(enc_r(7'h00, 5'd3, 5'd2, 3'b000, 5'd12), 16'h0104);
    expect_id_ex("addi", mk_ctrl(ALU_ADD, 4'b1001, 3'd0, 5'd0), 5'd11, -5, 16'h0100);
    check("addi rs1_val", rf_model[1], id_ex.rs1_val);
    present(enc_r(7'h20, 5'd5, 5'd4, 3'b000, 5'd13), 16'h0108);
    expect_id_ex("add", mk_ctrl(ALU_ADD, 4'b0001, 3'd0, 5'd0), 5'd12, '0, 16'h0104);
    check("add operands", {5'd2, 5'd3, rf_model[2], rf_model[3]},
          {id_ex.rs1, id_ex.rs2, id_ex.rs1_val, id_ex.rs2_val});
    present(enc_i(16, 5'd6, 3'b010, 5'd14, OP_LOAD), 16'h010c);
    expect_id_ex("sub", mk_ctrl(ALU_SUB, 4'b0001, 3'd0, 5'd0), 5'd13, '0, 16'h0108);
    check("sub operands", {rf_model[4], rf_model[5]}, {id_ex.rs1_val, id_ex.rs2_val});
    // SW x7, -8(x8), low offset bits land in the rd field
    present({7'h7f, 5'd7, 5'd8, 3'b010, 5'b11000, OP_STORE}, 16'h0110);
    expect_id_ex("lw", mk_ctrl(ALU_ADD, 4'b1101, 3'b010, 5'd0), 5'd14, 16, 16'h010c);
    check("lw rs1_val", rf_model[6], id_ex.rs1_val);
    present({20'habcde, 5'd15, OP_LUI}, 16'h0114);
    expect_id_ex("sw", mk_ctrl(ALU_ADD, 4'b1010, 3'b010, 5'd0), 5'd24, -8, 16'h0110);
    check("sw operands", {5'd8, 5'd7, rf_model[8], rf_model[7]},
          {id_ex.rs1, id_ex.rs2, id_ex.rs1_val, id_ex.rs2_val});
    present(NOP, 16'h0118);
    expect_id_ex("lui", mk_ctrl(ALU_ADD, 4'b1001, 3'd0, 5'b00010), 5'd15, 32'habcde000,
                 16'h0114);
  endtask

  task automatic load_use();
    present(enc_i(0, 5'd1, 3'b010, 5'd5, OP_LOAD), 16'h0120);
    present(enc_r(7'h00, 5'd2, 5'd5, 3'b000, 5'd6), 16'h0124);
    check("load_use hz", 1'b1, hz);
    // Fetch holds the ADD while the bubble goes in
    present(enc_r(7'h00, 5'd2, 5'd5, 3'b000, 5'd6), 16'h0124);
    expect_bubble("load_use bubble", 16'h0124);
    check("load_use hz after", 1'b0, hz);
    present(enc_i(0, 5'd1, 3'b010, 5'd5, OP_LOAD), 16'h0128);
    expect_id_ex("load_use add", mk_ctrl(ALU_ADD, 4'b0001, 3'd0, 5'd0), 5'd6, '0, 16'h0124);
    present(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd7), 16'h012c);
    check("independent hz", 1'b0, hz);
    present(NOP, 16'h0130);
  endtask

  // x8 comes from the source under test, x9 from the register file
  task automatic branch_case(input string name, input logic [2:0] f3, input word_t imm,
                             input int src, input word_t a, input pc_t p);
    ex_mem_t em;
    mem_wb_t mw;
    em = '0;
    mw = '0;
    case (src)
      0: em = '{1'b1, 1'b0, 5'd8, a};
      1: mw = '{1'b1, 5'd8, a};
      // Both later stages hold x8, EX/MEM must win
      3:
      begin
        em = '{1'b1, 1'b0, 5'd8, a};
        mw = '{1'b1, 5'd8, ~a};
      end
      default: em = '0;
    endcase
    @(posedge bus);
    ins    <= enc_b(imm, f3);
    pc     <= p;
    ex_mem <= em;
    mem_wb <= mw;
    @(negedge bus);
    check({name, " hz"}, 1'b0, hz);
    check({name, " taken"}, branch_cond(f3, a, rf_model[9]), branch_taken);
    check({name, " target"}, pc_t'(word_t'(p) + imm), branch_target);
    // Write-back lands on the next edge
    if (mw.regwrite)
      rf_model[8] = mw.wb_res;
  endtask

  task automatic branch_forwarding();
    branch_case("beq exmem", 3'b000, -16, 0, rf_model[9], 16'h0200);
    // Forwarded value equals x9, the stale x8 does not
    branch_case("bne memwb", 3'b001, 32, 1, rf_model[9], 16'h0204);
    branch_case("blt regfile", 3'b100, -2048, 2, rf_model[8], 16'h0208);
    seed = xorshift(seed);
    branch_case("bgeu exmem", 3'b111, 100, 0, seed, 16'h020c);
    branch_case("beq priority", 3'b000, 8, 3, rf_model[9], 16'h0210);
    // Load still in MEM, operand not ready
    // Register file x8 differs from x9, so only the stall keeps BNE from redirecting
    @(posedge bus);
    ins    <= enc_b(12, 3'b001);
    pc     <= 16'h0214;
    ex_mem <= '{1'b1, 1'b1, 5'd8, rf_model[9]};
    mem_wb <= '0;
    @(negedge bus);
    check("exmem load hz", 1'b1, hz);
    check("exmem load taken", 1'b0, branch_taken);
    @(posedge bus);
    ex_mem <= '0;
    present(NOP, 16'h0218);
    present(NOP, 16'h021c);
  endtask

  task automatic jumps_and_squash();
    word_t jimm;
    present({1'b0, 10'h000, 1'b1, 8'h00, 5'd1, OP_JAL}, 16'h0300);
    check("jal taken", 1'b1, branch_taken);
    check("jal target", pc_t'(16'h0b00), branch_target);
    present(enc_i(7, 5'd0, 3'b000, 5'd20, OP_OP_IMM), 16'h0304);
    expect_id_ex("jal", mk_ctrl(ALU_ADD, 4'b0001, 3'd0, 5'b01000), 5'd1, 32'h800, 16'h0300);
    present(enc_i(9, 5'd0, 3'b000, 5'd21, OP_OP_IMM), 16'h0b00);
    expect_bubble("jal squash", 16'h0304);
    // Odd sum so the cleared bit 0 shows
    jimm = rf_model[8][0] ? 32'd12 : 32'd13;
    present(enc_i(jimm, 5'd8, 3'b000, 5'd1, OP_JALR), 16'h0b04);
    expect_id_ex("after squash", mk_ctrl(ALU_ADD, 4'b1001, 3'd0, 5'd0), 5'd21, 9, 16'h0b00);
    check("jalr taken", 1'b1, branch_taken);
    check("jalr target", pc_t'((rf_model[8] + jimm) & ~32'd1), branch_target);
    present(enc_i(3, 5'd0, 3'b000, 5'd22, OP_OP_IMM), 16'h0b08);
    expect_id_ex("jalr", mk_ctrl(ALU_ADD, 4'b1001, 3'd0, 5'b00100), 5'd1, jimm, 16'h0b04);
    present(NOP, 16'h0b0c);
    expect_bubble("jalr squash", 16'h0b08);
  endtask

  task automatic hold_and_ecall();
    id_ex_t snap;
    word_t  codes [4];
    logic   exp_ecall [4];
    codes = '{32'h0000_0073, 32'h0010_0073, 32'h0000_00f3, 32'h0000_2183};
    exp_ecall = '{1'b1, 1'b0, 1'b0, 1'b0};
    present(enc_i(3, 5'd1, 3'b000, 5'd23, OP_OP_IMM), 16'h0400);
    @(posedge bus);
    ins      <= enc_i(5, 5'd2, 3'b000, 5'd24, OP_OP_IMM);
    pc       <= 16'h0404;
    mem_hold <= 1'b1;
    @(negedge bus);
    check("hold capture rd", 5'd23, id_ex.rd);
    snap = id_ex;
    for (int k = 0; k < 4; k++)
    begin
      present(codes[k], pc_t'(16'h0408 + 4 * k));
      check("ecall", exp_ecall[k], ecall);
      check("hold id_ex", snap, id_ex);
    end
    @(posedge bus);
    mem_hold <= 1'b0;
    ins      <= NOP;
    @(negedge bus);
    check("hold last edge", snap, id_ex);
    present(NOP, 16'h0420);
    check("released ctrl", '0, id_ex.ctrl);
  endtask

  //////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////

  initial
  begin
    rst      = 1'b1;
    ins      = NOP;
    pc       = '0;
    mem_hold = 1'b0;
    ex_mem   = '0;
    mem_wb   = '0;
    for (int r = 0; r < 32; r++)
      rf_model[r] = '0;
    repeat (10) @(posedge bus);
    rst <= 1'b0;
    @(negedge bus);
    reset_and_decode();
    load_use();
    branch_forwarding();
    jumps_and_squash();
    hold_and_ecall();
    $display("STATUS: PASS");
    $finish;
  end

  initial
  begin
    repeat (TEST_CYCLES * 2) @(posedge bus);
    $display("Timeout: the tests did not reach their end");
    $display("STATUS: FAIL");
    $fatal(1, "Watchdog expired");
  end

endmodule

`default_nettype wire

//--- rv_decode.f
common/rv_decode_pkg.sv
decode/rv_control.sv
decode/rv_imm_gen.sv
decode/rv_hazard_unit.sv
decode/rv_branch_unit.sv
decode/rv_id_ex_reg.sv
verilog/rv_regfile.sv
verilog/rv_decode_top.sv
sim/rv_decode_props.sv
sim/rv_decode_tb.sv
